// File: Makefile
# Verilator build and run for the receive calibration testbench

VERILATOR ?= verilator
TOP       ?= tb_rx_cal
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= all tests passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -F "$(PASS_MSG)" > /dev/null

clean:
	rm -rf $(OBJ_DIR)

// File: cal_apb_regs.sv
/*
  APB slave for calibration control and status.
  Zero wait states: pready_o is tied high.
  Unmapped addresses and writes to STATUS or SLIP raise pslverr_o and change nothing.
*/
`timescale 1ns/1ps
`default_nettype none

module cal_apb_regs #(
    parameter int unsigned LANES = 8
) (
    input  wire logic                    clk,
    input  wire logic                    reset,
    input  wire logic                    psel_i,
    input  wire logic                    penable_i,
    input  wire logic                    pwrite_i,
    input  wire cal_pkg::apb_addr_t      paddr_i,
    input  wire cal_pkg::apb_data_t      pwdata_i,
    output cal_pkg::apb_data_t           prdata_o,
    output logic                         pready_o,
    output logic                         pslverr_o,
    input  wire cal_pkg::cal_stat_t      stat_i,
    output cal_pkg::cal_cfg_t            cfg_o
);

    localparam cal_pkg::lane_vec_t USED = cal_pkg::lane_mask(LANES);

    logic           enable_r;
    cal_pkg::cnt_t  target_r;
    cal_pkg::cnt_t  limit_r;
    logic           access;
    logic           addr_ok;
    logic           addr_ro;
    logic           wr_en;

    always_comb begin
        access   = psel_i && penable_i;
        addr_ok  = 1'b1;
        addr_ro  = 1'b0;
        prdata_o = '0;
        case (paddr_i)
            cal_pkg::ADDR_CTRL: begin
                prdata_o = cal_pkg::apb_data_t'(enable_r);
            end
            cal_pkg::ADDR_TARGET: begin
                prdata_o = cal_pkg::apb_data_t'(target_r);
            end
            cal_pkg::ADDR_LIMIT: begin
                prdata_o = cal_pkg::apb_data_t'(limit_r);
            end
            cal_pkg::ADDR_STATUS: begin
                addr_ro  = 1'b1;
                prdata_o = cal_pkg::apb_data_t'({stat_i.timed_out, stat_i.done});
            end
            cal_pkg::ADDR_SLIP: begin
                addr_ro  = 1'b1;
                prdata_o = cal_pkg::apb_data_t'(stat_i.slip_vec & USED);
            end
            default: begin
                addr_ok = 1'b0;
            end
        endcase

        pready_o  = 1'b1;
        pslverr_o = access && (!addr_ok || (pwrite_i && addr_ro));
        wr_en     = access && pwrite_i && addr_ok && !addr_ro;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            enable_r <= 1'b0;
            target_r <= cal_pkg::RST_TARGET;
            limit_r  <= cal_pkg::RST_LIMIT;
        end else if (wr_en) begin
            case (paddr_i)
                cal_pkg::ADDR_CTRL:   enable_r <= pwdata_i[0];
                cal_pkg::ADDR_TARGET: target_r <= pwdata_i[15:0];
                cal_pkg::ADDR_LIMIT:  limit_r  <= pwdata_i[15:0];
                default: ;                           // Decode already filtered
            endcase
        end
    end

    always_comb begin
        cfg_o.enable        = enable_r;
        cfg_o.align_target  = target_r;
        cfg_o.timeout_limit = limit_r;
    end

    // Access phase always follows a setup phase with psel held
    a_penable_needs_psel: assert property (
        @(posedge clk) disable iff (reset)
        penable_i |-> psel_i
    ) else $error("penable high without psel");

endmodule

`default_nettype wire

// File: cal_checker.sv
/*
  Lane agreement check and bit-slip search.
  Search steps on a pos mismatch: slip differing lanes, invert, then clear.
  The valid sample right after a slip change is dropped as stale.
  done and timed_out hold until enable is cleared; clearing enable restarts the search.
*/
`timescale 1ns/1ps
`default_nettype none

module cal_checker #(
    parameter int unsigned LANES = 8
) (
    input  wire logic                    clk,
    input  wire logic                    reset,
    input  wire cal_pkg::lane_word_t     sample_i,
    input  wire cal_pkg::cal_cfg_t       cfg_i,
    output cal_pkg::cal_stat_t           stat_o
);

    localparam cal_pkg::lane_vec_t USED = cal_pkg::lane_mask(LANES);
    localparam cal_pkg::cnt_t STEP = 16'd2;          // Two half-samples per cycle

    cal_pkg::lane_vec_t  pos_diff;
    cal_pkg::lane_vec_t  neg_diff;
    logic                pos_match;
    logic                neg_match;
    logic                match;
    logic                finished;
    logic                flush;                      // Drop next valid sample
    logic                done;
    logic                timed_out;
    cal_pkg::slip_state_e state;
    cal_pkg::lane_vec_t  slip_vec;
    cal_pkg::cnt_t       aligned_cnt;
    cal_pkg::cnt_t       timeout_cnt;
    cal_pkg::cnt_t       aligned_nxt;
    cal_pkg::cnt_t       timeout_nxt;

    always_comb begin
        // Lanes that disagree with lane 0
        pos_diff    = (sample_i.pos ^ {cal_pkg::MAX_LANES{sample_i.pos[0]}}) & USED;
        neg_diff    = (sample_i.neg ^ {cal_pkg::MAX_LANES{sample_i.neg[0]}}) & USED;
        pos_match   = (pos_diff == '0);
        neg_match   = (neg_diff == '0);
        match       = pos_match && neg_match;
        finished    = done || timed_out;
        timeout_nxt = timeout_cnt + STEP;
        aligned_nxt = match ? aligned_cnt + STEP : '0;
    end

    always_ff @(posedge clk) begin
        if (reset || !cfg_i.enable) begin
            state       <= cal_pkg::SLIP_NONE;
            slip_vec    <= '0;
            aligned_cnt <= '0;
            timeout_cnt <= '0;
            flush       <= 1'b0;
            done        <= 1'b0;
            timed_out   <= 1'b0;
        end else if (!finished) begin
            timeout_cnt <= timeout_nxt;
            if (timeout_nxt >= cfg_i.timeout_limit) begin
                timed_out <= 1'b1;
            end

            if (sample_i.valid) begin
                if (flush) begin
                    flush <= 1'b0;                   // Captured with the old slip
                end else begin
                    aligned_cnt <= aligned_nxt;
                    if (match && aligned_nxt >= cfg_i.align_target) begin
                        done <= 1'b1;
                    end

                    if (!pos_match) begin
                        flush <= 1'b1;
                        case (state)
                            cal_pkg::SLIP_NONE: begin
                                slip_vec <= pos_diff;
                                state    <= cal_pkg::SLIP_TRIED;
                            end
                            cal_pkg::SLIP_TRIED: begin
                                slip_vec <= ~slip_vec & USED;
                                state    <= cal_pkg::SLIP_INVERTED;
                            end
                            default: begin
                                slip_vec <= '0;
                                state    <= cal_pkg::SLIP_NONE;
                            end
                        endcase
                    end
                end
            end
        end
    end

    always_comb begin
        stat_o.done      = done;
        stat_o.timed_out = timed_out;
        stat_o.slip_vec  = slip_vec;
    end

    // Status only develops while the search is enabled
    a_idle_when_disabled: assert property (
        @(posedge clk) disable iff (reset)
        !cfg_i.enable |=> !(stat_o.done || stat_o.timed_out)
    ) else $error("status set while disabled");

    // Lock found; slip vector must hold until software restarts
    a_slip_frozen: assert property (
        @(posedge clk) disable iff (reset)
        (stat_o.done && cfg_i.enable) |=> $stable(stat_o.slip_vec)
    ) else $error("slip vector changed after done");

endmodule

`default_nettype wire

// File: cal_pkg.sv
/*
  Shared types and register map for the receive calibration block.
  Lane words are sized for MAX_LANES; designs with fewer lanes use the low bits only.
  Counts are in half-samples and compared with >=, so even limits are expected.
*/
`default_nettype none

package cal_pkg;

    localparam int unsigned LANES_DEF = 8;
    localparam int unsigned MAX_LANES = 16;

    typedef logic [15:0] cnt_t;          // Half-sample counts
    typedef logic [7:0]  apb_addr_t;
    typedef logic [31:0] apb_data_t;
    typedef logic [MAX_LANES-1:0] lane_vec_t;

    typedef struct packed {
        logic      valid;
        lane_vec_t pos;                  // Rising-edge word
        lane_vec_t neg;                  // Falling-edge word
    } lane_word_t;

    typedef struct packed {
        logic enable;
        cnt_t align_target;
        cnt_t timeout_limit;
    } cal_cfg_t;

    typedef struct packed {
        logic      done;
        logic      timed_out;
        lane_vec_t slip_vec;
    } cal_stat_t;

    typedef enum logic [1:0] {
        SLIP_NONE     = 2'd0,
        SLIP_TRIED    = 2'd1,
        SLIP_INVERTED = 2'd2
    } slip_state_e;

    localparam apb_addr_t ADDR_CTRL   = 8'h00;
    localparam apb_addr_t ADDR_TARGET = 8'h04;
    localparam apb_addr_t ADDR_LIMIT  = 8'h08;
    localparam apb_addr_t ADDR_STATUS = 8'h0C;   // Read only
    localparam apb_addr_t ADDR_SLIP   = 8'h10;   // Read only

    localparam cnt_t RST_TARGET = 16'd64;
    localparam cnt_t RST_LIMIT  = 16'd640;

    // Bit mask of the lanes actually in use
    function automatic lane_vec_t lane_mask(input int unsigned lanes);
        lane_vec_t m;
        m = '0;
        for (int i = 0; i < MAX_LANES; i++) begin
            if (i < lanes) begin
                m[i] = 1'b1;
            end
        end
        return m;
    endfunction

endpackage

`default_nettype wire

// File: files.f
cal_pkg.sv
lane_capture.sv
cal_checker.sv
cal_apb_regs.sv
rx_cal_top.sv
tb_rx_cal.sv

// File: lane_capture.sv
/*
  Input stage. One cycle from the link pins to sample_o.
  A slipped lane presents last cycle's neg bit as pos and the current pos bit as neg.
  slip_vec_i must only have bits set below LANES.
*/
`timescale 1ns/1ps
`default_nettype none

module lane_capture #(
    parameter int unsigned LANES = 8
) (
    input  wire logic                    clk,
    input  wire logic                    reset,
    input  wire logic [LANES-1:0]        pos_data_i,
    input  wire logic [LANES-1:0]        neg_data_i,
    input  wire logic                    link_valid_i,
    input  wire cal_pkg::lane_vec_t      slip_vec_i,
    output cal_pkg::lane_word_t          sample_o
);

    localparam cal_pkg::lane_vec_t USED = cal_pkg::lane_mask(LANES);

    cal_pkg::lane_vec_t pos_ext;
    cal_pkg::lane_vec_t neg_ext;
    cal_pkg::lane_vec_t neg_prev;        // Neg word of the previous cycle
    cal_pkg::lane_vec_t pos_sel;
    cal_pkg::lane_vec_t neg_sel;

    always_comb begin
        pos_ext = cal_pkg::lane_vec_t'(pos_data_i);
        neg_ext = cal_pkg::lane_vec_t'(neg_data_i);
        // Slipped lanes shift back by half a cycle
        pos_sel = (slip_vec_i & neg_prev) | (~slip_vec_i & pos_ext);
        neg_sel = (slip_vec_i & pos_ext)  | (~slip_vec_i & neg_ext);
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            sample_o.valid <= 1'b0;
        end else begin
            sample_o.valid <= link_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        neg_prev     <= neg_ext;
        sample_o.pos <= pos_sel & USED;
        sample_o.neg <= neg_sel & USED;
    end

    // The checker must never request a slip on a lane that does not exist
    a_slip_in_range: assert property (
        @(posedge clk) disable iff (reset)
        (slip_vec_i & ~USED) == '0
    ) else $error("slip bit set above lane count");

endmodule

`default_nettype wire

// File: rx_cal_top.sv
/*
  Receive calibration top: capture, checker and APB register block.
  LANES may be 1 to 16. The link has no flow control.
*/
`timescale 1ns/1ps
`default_nettype none

module rx_cal_top #(
    parameter int unsigned LANES = cal_pkg::LANES_DEF
) (
    input  wire logic                    clk,
    input  wire logic                    reset,
    input  wire logic [LANES-1:0]        pos_data_i,
    input  wire logic [LANES-1:0]        neg_data_i,
    input  wire logic                    link_valid_i,
    input  wire logic                    psel_i,
    input  wire logic                    penable_i,
    input  wire logic                    pwrite_i,
    input  wire cal_pkg::apb_addr_t      paddr_i,
    input  wire cal_pkg::apb_data_t      pwdata_i,
    output cal_pkg::apb_data_t           prdata_o,
    output logic                         pready_o,
    output logic                         pslverr_o
);

    cal_pkg::lane_word_t sample;
    cal_pkg::cal_cfg_t   cfg;
    cal_pkg::cal_stat_t  stat;

    if (LANES < 1 || LANES > cal_pkg::MAX_LANES) begin : g_bad_lanes
        $error("LANES out of range");
    end

    lane_capture #(.LANES(LANES)) u_capture (
        .clk          (clk),
        .reset        (reset),
        .pos_data_i   (pos_data_i),
        .neg_data_i   (neg_data_i),
        .link_valid_i (link_valid_i),
        .slip_vec_i   (stat.slip_vec),
        .sample_o     (sample)
    );

    cal_checker #(.LANES(LANES)) u_checker (
        .clk      (clk),
        .reset    (reset),
        .sample_i (sample),
        .cfg_i    (cfg),
        .stat_o   (stat)
    );

    cal_apb_regs #(.LANES(LANES)) u_regs (
        .clk       (clk),
        .reset     (reset),
        .psel_i    (psel_i),
        .penable_i (penable_i),
        .pwrite_i  (pwrite_i),
        .paddr_i   (paddr_i),
        .pwdata_i  (pwdata_i),
        .prdata_o  (prdata_o),
        .pready_o  (pready_o),
        .pslverr_o (pslverr_o),
        .stat_i    (stat),
        .cfg_o     (cfg)
    );

endmodule

`default_nettype wire

// File: tb_rx_cal.sv
/*
  Self-checking testbench for rx_cal_top with 8 lanes.
  Inputs change on the falling clock edge. APB results are sampled 1 ns into the access phase.
  The run stops at the first failed check.
*/
`timescale 1ns/1ps
`default_nettype none

module tb_rx_cal;

    localparam int LANES       = 8;
    localparam int CLK_PERIOD  = 4;
    localparam int XFER_CYCLES = 3;               // Setup, access, idle
    localparam int POLL_MAX    = 300;             // Status reads per wait
    localparam int TEST_CYCLES = 3 * POLL_MAX * XFER_CYCLES + 40 * XFER_CYCLES + 50;
    localparam int WATCHDOG_NS = (TEST_CYCLES + 200) * CLK_PERIOD;

    logic               clk;
    logic               reset;
    logic [LANES-1:0]   pos_data;
    logic [LANES-1:0]   neg_data;
    logic               link_valid;
    logic               psel;
    logic               penable;
    logic               pwrite;
    cal_pkg::apb_addr_t paddr;
    cal_pkg::apb_data_t pwdata;
    cal_pkg::apb_data_t prdata;
    logic               pready;
    logic               pslverr;

    logic [LANES-1:0]   skew_mask;                // Lanes driven half a cycle early
    logic               random_mode;
    logic [31:0]        rnd;
    integer             seed;
    string              test_name;

    rx_cal_top #(.LANES(LANES)) u_dut (
        .clk          (clk),
        .reset        (reset),
        .pos_data_i   (pos_data),
        .neg_data_i   (neg_data),
        .link_valid_i (link_valid),
        .psel_i       (psel),
        .penable_i    (penable),
        .pwrite_i     (pwrite),
        .paddr_i      (paddr),
        .pwdata_i     (pwdata),
        .prdata_o     (prdata),
        .pready_o     (pready),
        .pslverr_o    (pslverr)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // Link model: training pattern, or noise on every lane
    always @(negedge clk) begin
        if (random_mode) begin
            rnd      = $random(seed);
            pos_data = rnd[LANES-1:0];
            rnd      = $random(seed);
            neg_data = rnd[LANES-1:0];
        end else begin
            pos_data = ~skew_mask;
            neg_data = skew_mask;
        end
    end

    task automatic fail_stop(input string msg);
        $display("%s", msg);
        $display("tests failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_value(input string what, input logic [31:0] exp,
                               input logic [31:0] act);
        assert (act === exp) else begin
            fail_stop($sformatf("FAILED %s %s: expected 0x%0h actual 0x%0h",
                                test_name, what, exp, act));
        end
    endtask

    task automatic apb_xfer(input logic wr, input cal_pkg::apb_addr_t addr,
                            input cal_pkg::apb_data_t data,
                            output cal_pkg::apb_data_t rdata, output logic err);
        @(negedge clk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = data;
        @(negedge clk);
        penable = 1'b1;
        #1;
        rdata = prdata;
        err   = pslverr;
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_write(input cal_pkg::apb_addr_t addr, input cal_pkg::apb_data_t data,
                             input logic exp_err);
        cal_pkg::apb_data_t rd;
        logic               err;
        apb_xfer(1'b1, addr, data, rd, err);
        check_value($sformatf("pslverr on write to 0x%0h", addr), 32'(exp_err), 32'(err));
    endtask

    task automatic apb_read_check(input cal_pkg::apb_addr_t addr,
                                  input cal_pkg::apb_data_t exp);
        cal_pkg::apb_data_t rd;
        logic               err;
        apb_xfer(1'b0, addr, '0, rd, err);
        check_value($sformatf("pslverr on read of 0x%0h", addr), 32'd0, 32'(err));
        check_value($sformatf("read of 0x%0h", addr), exp, rd);
    endtask

    // Poll STATUS until done or timed_out shows up
    task automatic wait_status(output cal_pkg::apb_data_t st);
        int   polls;
        logic err;
        polls = 0;
        st    = '0;
        while (st[1:0] == 2'b00 && polls < POLL_MAX) begin
            apb_xfer(1'b0, cal_pkg::ADDR_STATUS, '0, st, err);
            polls++;
        end
        if (st[1:0] == 2'b00) begin
            fail_stop($sformatf("%s: calibration neither finished nor timed out", test_name));
        end
    endtask

    a_pready_high: assert property (@(posedge clk) disable iff (reset) pready)
        else fail_stop($sformatf("%s: pready went low", test_name));

    a_err_in_access: assert property (
        @(posedge clk) disable iff (reset) pslverr |-> (psel && penable)
    ) else fail_stop($sformatf("%s: pslverr outside an access phase", test_name));

    // Noise must never look like a lock
    a_no_lock_on_noise: assert property (
        @(posedge clk) disable iff (reset) random_mode |-> !u_dut.stat.done
    ) else fail_stop($sformatf("%s: done set on random data", test_name));

    initial begin
        cal_pkg::apb_data_t st;
        logic               err;
        clk         = 1'b0;
        reset       = 1'b1;
        seed        = 81623;
        test_name   = "reset";
        skew_mask   = '0;
        random_mode = 1'b0;
        pos_data    = '0;
        neg_data    = '0;
        link_valid  = 1'b1;
        psel        = 1'b0;
        penable     = 1'b0;
        pwrite      = 1'b0;
        paddr       = '0;
        pwdata      = '0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        test_name = "reset_values";
        apb_read_check(cal_pkg::ADDR_STATUS, 32'd0);
        apb_read_check(cal_pkg::ADDR_SLIP, 32'd0);
        apb_read_check(cal_pkg::ADDR_TARGET, 32'(cal_pkg::RST_TARGET));
        apb_read_check(cal_pkg::ADDR_LIMIT, 32'(cal_pkg::RST_LIMIT));

        test_name = "apb_access";
        apb_write(cal_pkg::ADDR_TARGET, 32'h0000_0123, 1'b0);
        apb_read_check(cal_pkg::ADDR_TARGET, 32'h0000_0123);
        apb_write(cal_pkg::ADDR_LIMIT, 32'h0000_0456, 1'b0);
        apb_read_check(cal_pkg::ADDR_LIMIT, 32'h0000_0456);
        apb_xfer(1'b0, 8'h14, '0, st, err);
        check_value("pslverr on read of 0x14", 32'd1, 32'(err));
        apb_write(cal_pkg::ADDR_STATUS, 32'h0000_0003, 1'b1);
        apb_read_check(cal_pkg::ADDR_STATUS, 32'd0);
        apb_write(cal_pkg::ADDR_TARGET, 32'(cal_pkg::RST_TARGET), 1'b0);
        apb_write(cal_pkg::ADDR_LIMIT, 32'(cal_pkg::RST_LIMIT), 1'b0);

        test_name = "aligned_link";
        apb_write(cal_pkg::ADDR_CTRL, 32'd1, 1'b0);
        wait_status(st);
        check_value("status", 32'd1, st);            // done without timeout
        apb_read_check(cal_pkg::ADDR_SLIP, 32'd0);
        apb_write(cal_pkg::ADDR_CTRL, 32'd0, 1'b0);

        test_name = "skewed_lanes";
        skew_mask = 8'h0A;
        apb_write(cal_pkg::ADDR_CTRL, 32'd1, 1'b0);
        wait_status(st);
        check_value("status", 32'd1, st);
        apb_read_check(cal_pkg::ADDR_SLIP, 32'h0000_000A);
        skew_mask = '0;                               // Slipped lanes now disagree
        repeat (20) @(negedge clk);
        apb_read_check(cal_pkg::ADDR_SLIP, 32'h0000_000A);  // Still frozen
        apb_read_check(cal_pkg::ADDR_STATUS, 32'd1);
        apb_write(cal_pkg::ADDR_CTRL, 32'd0, 1'b0);

        test_name = "random_timeout";
        apb_write(cal_pkg::ADDR_LIMIT, 32'd200, 1'b0);
        random_mode = 1'b1;
        apb_write(cal_pkg::ADDR_CTRL, 32'd1, 1'b0);
        wait_status(st);
        check_value("status", 32'd2, st);            // timed_out only
        apb_write(cal_pkg::ADDR_CTRL, 32'd0, 1'b0);
        apb_read_check(cal_pkg::ADDR_STATUS, 32'd0);
        random_mode = 1'b0;

        $display("all tests passed");
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        fail_stop("watchdog expired before the tests completed");
    end

endmodule

`default_nettype wire
